/* hw/ps_cpld_pkg.sv */
// shared definitions for the ps cpld base register block
//   controlport widths and response status codes
//   register offsets inside the 64-word window
//   identification constants and dio field placement
//   pl_db word, decoded as write flags or read status
package ps_cpld_pkg;

  //--------------------------------------------------------------------------
  // controlport
  //--------------------------------------------------------------------------
  localparam int ctrlport_addr_w = 20;
  localparam int ctrlport_data_w = 32;

  localparam logic [1:0] ctrl_sts_okay   = 2'b00;
  localparam logic [1:0] ctrl_sts_cmderr = 2'b01;

  // decoded window, base must be aligned to it
  localparam int num_addresses = 64;
  localparam int window_w      = $clog2(num_addresses);

  //--------------------------------------------------------------------------
  // register offsets
  //--------------------------------------------------------------------------
  localparam logic [window_w-1:0] signature_reg       = 6'h00;
  localparam logic [window_w-1:0] revision_reg        = 6'h04;
  localparam logic [window_w-1:0] oldest_revision_reg = 6'h08;
  localparam logic [window_w-1:0] scratch_reg_addr    = 6'h0C;
  localparam logic [window_w-1:0] git_hash_reg        = 6'h10;
  localparam logic [window_w-1:0] pl_db_reg           = 6'h20;
  localparam logic [window_w-1:0] dio_direction_reg   = 6'h30;

  // id words, revisions in yymmddhh
  localparam logic [ctrlport_data_w-1:0] ps_cpld_signature    = 32'h0A52_2D27;
  localparam logic [ctrlport_data_w-1:0] cpld_revision        = 32'h2106_1408;
  localparam logic [ctrlport_data_w-1:0] oldest_cpld_revision = 32'h2103_0211;
  // clean tree, 7 digit hash
  localparam logic [ctrlport_data_w-1:0] git_hash_value       = 32'h03C4_91FA;

  // dio word: field a at 11:0, field b at 27:16
  localparam int dio_dir_w     = 12;
  localparam int dio_dir_b_lsb = 16;

  //--------------------------------------------------------------------------
  // pl_db word
  //--------------------------------------------------------------------------
  // bit 0 of each pair is db0, bit 1 is db1
  typedef union packed {
    struct packed {
      logic [9:0] rsvd_31_22;
      logic [1:0] assert_reset;
      logic [1:0] rsvd_19_18;
      logic [1:0] release_reset;
      logic       rsvd_15;
      logic       disable_pll_ref_clk;
      logic [1:0] disable_db_clk;
      logic       rsvd_11;
      logic       enable_pll_ref_clk;
      logic [1:0] enable_db_clk;
      logic [7:0] rsvd_7_0;
    } wr;
    struct packed {
      logic [25:0] rsvd_31_6;
      logic [1:0]  db_reset_asserted;
      logic        rsvd_3;
      logic        pll_ref_clk_enabled;
      logic [1:0]  db_clk_enabled;
    } rd;
  } pl_db_word_u;

endpackage

/* hw/cfg_bus_if.sv */
// decoder to configuration register link
//   write strobes and write data from the decoder
//   scratch and placed dio word back for readback
`timescale 1ns/1ps

interface cfg_bus_if;
  import ps_cpld_pkg::*;

  // one-cycle strobes, valid with wdata in the request cycle
  logic                       scratch_wr;
  logic                       dio_wr;
  logic [ctrlport_data_w-1:0] wdata;

  // current register contents
  logic [ctrlport_data_w-1:0] scratch;
  // fields already at their bit positions, rest zero
  logic [ctrlport_data_w-1:0] dio_dir;

  modport decoder (
    output scratch_wr, dio_wr, wdata,
    input  scratch, dio_dir
  );

  modport regs (
    input  scratch_wr, dio_wr, wdata,
    output scratch, dio_dir
  );

endinterface

/* hw/ctrlport_decoder.sv */
// controlport request decoder for the base register window
//   window check and offset match
//   write strobes to the configuration and daughterboard blocks
//   id word constants and read data mux
//   registered response, one cycle after the request
`timescale 1ns/1ps

module ctrlport_decoder #(
  parameter logic [ps_cpld_pkg::ctrlport_addr_w-1:0] base_address = '0
) (
  input  logic                                      ctrlport_clk,
  input  logic                                      ctrlport_rst,
  input  logic                                      req_wr,
  input  logic                                      req_rd,
  input  logic [ps_cpld_pkg::ctrlport_addr_w-1:0]   req_addr,
  input  logic [ps_cpld_pkg::ctrlport_data_w-1:0]   req_data,
  cfg_bus_if.decoder                                cfg,
  output logic                                      db_wr,
  input  logic [ps_cpld_pkg::ctrlport_data_w-1:0]   db_status,
  output logic                                      resp_ack,
  output logic [1:0]                                resp_status,
  output logic [ps_cpld_pkg::ctrlport_data_w-1:0]   resp_data
);
  import ps_cpld_pkg::*;

  logic                       in_window;
  logic [window_w-1:0]        offset;
  logic                       req_valid;
  logic                       wr_hit;
  logic                       addr_defined;
  logic                       scratch_sel;
  logic                       dio_sel;
  logic                       db_sel;
  logic [ctrlport_data_w-1:0] rd_word;

  //--------------------------------------------------------------------------
  // address decode
  //--------------------------------------------------------------------------
  // aligned base, so upper bits select the window
  assign in_window = (req_addr[ctrlport_addr_w-1:window_w] ==
                      base_address[ctrlport_addr_w-1:window_w]);
  assign offset    = req_addr[window_w-1:0];

  // no ack at all outside the window
  assign req_valid = (req_wr || req_rd) && in_window;
  assign wr_hit    = req_wr && in_window;

  always_comb begin
    rd_word      = '0;
    addr_defined = 1'b1;
    scratch_sel  = 1'b0;
    dio_sel      = 1'b0;
    db_sel       = 1'b0;
    case (offset)
      // read-only id words, writes ignored
      signature_reg:       rd_word = ps_cpld_signature;
      revision_reg:        rd_word = cpld_revision;
      oldest_revision_reg: rd_word = oldest_cpld_revision;
      git_hash_reg:        rd_word = git_hash_value;
      scratch_reg_addr: begin
        rd_word     = cfg.scratch;
        scratch_sel = 1'b1;
      end
      pl_db_reg: begin
        rd_word = db_status;
        db_sel  = 1'b1;
      end
      dio_direction_reg: begin
        rd_word = cfg.dio_dir;
        dio_sel = 1'b1;
      end
      // hole in the window, cmderr with zero data
      default: addr_defined = 1'b0;
    endcase
  end

  //--------------------------------------------------------------------------
  // write strobes
  //--------------------------------------------------------------------------
  // combinational in the request cycle, blocks update on the same edge
  assign cfg.scratch_wr = wr_hit && scratch_sel;
  assign cfg.dio_wr     = wr_hit && dio_sel;
  assign cfg.wdata      = req_data;
  assign db_wr          = wr_hit && db_sel;

  //--------------------------------------------------------------------------
  // response
  //--------------------------------------------------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack    <= 1'b0;
      resp_status <= ctrl_sts_okay;
      resp_data   <= '0;
    end else begin
      // single-cycle ack pulse
      resp_ack <= req_valid;
      if (req_valid) begin
        resp_status <= addr_defined ? ctrl_sts_okay : ctrl_sts_cmderr;
        // write wins over read, and returns no data
        resp_data   <= req_wr ? '0 : rd_word;
      end
    end
  end

endmodule

/* hw/config_regs.sv */
// software configuration registers
//   scratch word
//   dio buffer direction fields a and b
`timescale 1ns/1ps

module config_regs (
  input  logic                               ctrlport_clk,
  input  logic                               ctrlport_rst,
  cfg_bus_if.regs                            cfg,
  output logic [ps_cpld_pkg::dio_dir_w-1:0]  dio_direction_a,
  output logic [ps_cpld_pkg::dio_dir_w-1:0]  dio_direction_b
);
  import ps_cpld_pkg::*;

  logic [ctrlport_data_w-1:0] scratch_q;
  logic [dio_dir_w-1:0]       dir_a_q;
  logic [dio_dir_w-1:0]       dir_b_q;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      scratch_q <= '0;
      dir_a_q   <= '0;
      dir_b_q   <= '0;
    end else begin
      if (cfg.scratch_wr) begin
        scratch_q <= cfg.wdata;
      end
      // other bits of the word are dropped
      if (cfg.dio_wr) begin
        dir_a_q <= cfg.wdata[dio_dir_w-1:0];
        dir_b_q <= cfg.wdata[dio_dir_b_lsb +: dio_dir_w];
      end
    end
  end

  // readback word, fields in place
  always_comb begin
    cfg.dio_dir                               = '0;
    cfg.dio_dir[dio_dir_w-1:0]                = dir_a_q;
    cfg.dio_dir[dio_dir_b_lsb +: dio_dir_w]   = dir_b_q;
  end

  assign cfg.scratch     = scratch_q;
  assign dio_direction_a = dir_a_q;
  assign dio_direction_b = dir_b_q;

endmodule

/* hw/db_power_ctrl.sv */
// daughterboard clock and reset control
//   db0/db1 clock enables and pll reference clock enable
//   db0/db1 reset, asserted out of reset
//   status word in the pl_db read layout
`timescale 1ns/1ps

module db_power_ctrl (
  input  logic                                    ctrlport_clk,
  input  logic                                    ctrlport_rst,
  input  logic                                    db_wr,
  input  logic [ps_cpld_pkg::ctrlport_data_w-1:0] wdata,
  output logic [1:0]                              db_clk_enable,
  output logic [1:0]                              db_reset,
  output logic                                    pll_ref_clk_enable,
  output logic [ps_cpld_pkg::ctrlport_data_w-1:0] db_status
);
  import ps_cpld_pkg::*;

  pl_db_word_u cmd;
  pl_db_word_u status_word;

  // incoming word seen as command flags
  assign cmd = wdata;

  //--------------------------------------------------------------------------
  // state bits
  //--------------------------------------------------------------------------
  // clocks: disable beats enable
  // resets: assert beats release
  // no flag for a bit leaves it alone
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      db_clk_enable      <= 2'b00;
      db_reset           <= 2'b11;
      pll_ref_clk_enable <= 1'b0;
    end else if (db_wr) begin
      db_clk_enable      <= (db_clk_enable | cmd.wr.enable_db_clk) &
                            ~cmd.wr.disable_db_clk;
      pll_ref_clk_enable <= (pll_ref_clk_enable | cmd.wr.enable_pll_ref_clk) &
                            ~cmd.wr.disable_pll_ref_clk;
      db_reset           <= (db_reset & ~cmd.wr.release_reset) |
                            cmd.wr.assert_reset;
    end
  end

  //--------------------------------------------------------------------------
  // status readback
  //--------------------------------------------------------------------------
  always_comb begin
    status_word                        = '0;
    status_word.rd.db_clk_enabled      = db_clk_enable;
    status_word.rd.pll_ref_clk_enabled = pll_ref_clk_enable;
    status_word.rd.db_reset_asserted   = db_reset;
  end

  assign db_status = status_word;

endmodule

/* hw/ps_cpld_regs.sv */
// ps cpld base register block, top level
//   controlport decoder
//   scratch and dio direction registers
//   daughterboard clock and reset control
`timescale 1ns/1ps

module ps_cpld_regs #(
  parameter logic [ps_cpld_pkg::ctrlport_addr_w-1:0] base_address = '0
) (
  input  logic                                    ctrlport_clk,
  input  logic                                    ctrlport_rst,

  // controlport request
  input  logic                                    req_wr,
  input  logic                                    req_rd,
  input  logic [ps_cpld_pkg::ctrlport_addr_w-1:0] req_addr,
  input  logic [ps_cpld_pkg::ctrlport_data_w-1:0] req_data,
  // controlport response
  output logic                                    resp_ack,
  output logic [1:0]                              resp_status,
  output logic [ps_cpld_pkg::ctrlport_data_w-1:0] resp_data,

  // configuration outputs
  output logic [1:0]                              db_clk_enable,
  output logic [1:0]                              db_reset,
  output logic                                    pll_ref_clk_enable,
  output logic [ps_cpld_pkg::dio_dir_w-1:0]       dio_direction_a,
  output logic [ps_cpld_pkg::dio_dir_w-1:0]       dio_direction_b
);
  import ps_cpld_pkg::*;

  logic                       db_wr;
  logic [ctrlport_data_w-1:0] db_status;

  cfg_bus_if cfg ();

  ctrlport_decoder #(
    .base_address (base_address)
  ) decoder_i (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (req_wr),
    .req_rd       (req_rd),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .cfg          (cfg.decoder),
    .db_wr        (db_wr),
    .db_status    (db_status),
    .resp_ack     (resp_ack),
    .resp_status  (resp_status),
    .resp_data    (resp_data)
  );

  config_regs config_regs_i (
    .ctrlport_clk    (ctrlport_clk),
    .ctrlport_rst    (ctrlport_rst),
    .cfg             (cfg.regs),
    .dio_direction_a (dio_direction_a),
    .dio_direction_b (dio_direction_b)
  );

  // write data straight from the request, strobe from the decoder
  db_power_ctrl db_power_ctrl_i (
    .ctrlport_clk       (ctrlport_clk),
    .ctrlport_rst       (ctrlport_rst),
    .db_wr              (db_wr),
    .wdata              (req_data),
    .db_clk_enable      (db_clk_enable),
    .db_reset           (db_reset),
    .pll_ref_clk_enable (pll_ref_clk_enable),
    .db_status          (db_status)
  );

endmodule

/* sim/ps_cpld_assertions.sv */
// decoder response protocol checks, bound into ctrlport_decoder
//   single-cycle ack
//   no ack after an out-of-window request
//   okay status on writes to defined offsets
`timescale 1ns/1ps

module ps_cpld_assertions #(
  parameter logic [ps_cpld_pkg::ctrlport_addr_w-1:0] base_address = '0
) (
  input logic                                    ctrlport_clk,
  input logic                                    ctrlport_rst,
  input logic                                    req_wr,
  input logic                                    req_rd,
  input logic [ps_cpld_pkg::ctrlport_addr_w-1:0] req_addr,
  input logic                                    resp_ack,
  input logic [1:0]                              resp_status
);
  import ps_cpld_pkg::*;

  logic in_window;
  logic known_offset;
  // failed assertions so far
  int   fail_count = 0;

  assign in_window = (req_addr[ctrlport_addr_w-1:window_w] ==
                      base_address[ctrlport_addr_w-1:window_w]);

  always_comb begin
    case (req_addr[window_w-1:0])
      signature_reg, revision_reg, oldest_revision_reg, scratch_reg_addr,
      git_hash_reg, pl_db_reg, dio_direction_reg: known_offset = 1'b1;
      default: known_offset = 1'b0;
    endcase
  end

  ack_one_cycle: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    resp_ack |=> !resp_ack)
    else begin
      $error("resp_ack high for two cycles in a row");
      fail_count++;
    end

  // outside the window the request is simply dropped
  no_ack_outside: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    ((req_wr || req_rd) && !in_window) |=> !resp_ack)
    else begin
      $error("resp_ack after an out-of-window request");
      fail_count++;
    end

  write_okay: assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    (req_wr && in_window && known_offset) |=> (resp_ack && resp_status == ctrl_sts_okay))
    else begin
      $error("write to a defined offset not acked with okay");
      fail_count++;
    end

endmodule

bind ctrlport_decoder ps_cpld_assertions #(
  .base_address (base_address)
) protocol_checks_i (
  .ctrlport_clk (ctrlport_clk),
  .ctrlport_rst (ctrlport_rst),
  .req_wr       (req_wr),
  .req_rd       (req_rd),
  .req_addr     (req_addr),
  .resp_ack     (resp_ack),
  .resp_status  (resp_status)
);

/* sim/ps_cpld_checker.sv */
// response and configuration output checker
//   reference model of the register window
//   per-cycle comparison on the falling clock edge
//   per-test report lines and running counts
`timescale 1ns/1ps

module ps_cpld_checker #(
  parameter logic [ps_cpld_pkg::ctrlport_addr_w-1:0] base_address = '0
) (
  input  logic                                    ctrlport_clk,
  input  logic                                    ctrlport_rst,
  input  logic                                    req_wr,
  input  logic                                    req_rd,
  input  logic [ps_cpld_pkg::ctrlport_addr_w-1:0] req_addr,
  input  logic [ps_cpld_pkg::ctrlport_data_w-1:0] req_data,
  input  logic                                    resp_ack,
  input  logic [1:0]                              resp_status,
  input  logic [ps_cpld_pkg::ctrlport_data_w-1:0] resp_data,
  input  logic [1:0]                              db_clk_enable,
  input  logic [1:0]                              db_reset,
  input  logic                                    pll_ref_clk_enable,
  input  logic [ps_cpld_pkg::dio_dir_w-1:0]       dio_direction_a,
  input  logic [ps_cpld_pkg::dio_dir_w-1:0]       dio_direction_b,
  input  int                                      test_id,
  input  logic                                    test_end,
  output int                                      check_count,
  output int                                      error_count,
  output int                                      test_count
);
  import ps_cpld_pkg::*;

  // model state
  logic [31:0] m_scratch;
  logic [11:0] m_dir_a;
  logic [11:0] m_dir_b;
  logic [1:0]  m_clk_en;
  logic        m_pll;
  logic [1:0]  m_rst;

  // response expected after the next rising edge
  logic        exp_ack;
  logic [1:0]  exp_status;
  logic [31:0] exp_data;
  logic        after_reset;
  logic [5:0]  off;
  int          test_checks;
  int          test_errors;

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset_values";
      2:       return "id_words";
      3:       return "scratch_dio";
      4:       return "db_control";
      5:       return "response_rules";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic defined_offset(input logic [5:0] o);
    return (o == 6'h00) || (o == 6'h04) || (o == 6'h08) || (o == 6'h0C) ||
           (o == 6'h10) || (o == 6'h20) || (o == 6'h30);
  endfunction

  function automatic logic [31:0] read_word(input logic [5:0] o);
    case (o)
      6'h00:   return ps_cpld_signature;
      6'h04:   return cpld_revision;
      6'h08:   return oldest_cpld_revision;
      6'h0C:   return m_scratch;
      6'h10:   return git_hash_value;
      // status: clocks 1:0, pll 2, resets 5:4
      6'h20:   return {26'b0, m_rst, 1'b0, m_pll, m_clk_en};
      6'h30:   return {4'b0, m_dir_b, 4'b0, m_dir_a};
      default: return 32'h0;
    endcase
  endfunction

  // enable 10:8, disable 14:12, release 17:16, assert 21:20
  task automatic apply_db_flags(input logic [31:0] d);
    for (int i = 0; i < 2; i++) begin
      if (d[12+i])
        m_clk_en[i] = 1'b0;
      else if (d[8+i])
        m_clk_en[i] = 1'b1;
      if (d[20+i])
        m_rst[i] = 1'b1;
      else if (d[16+i])
        m_rst[i] = 1'b0;
    end
    if (d[14])
      m_pll = 1'b0;
    else if (d[10])
      m_pll = 1'b1;
  endtask

  task automatic apply_write(input logic [5:0] o, input logic [31:0] d);
    case (o)
      6'h0C: m_scratch = d;
      6'h20: apply_db_flags(d);
      6'h30: begin
        m_dir_a = d[11:0];
        m_dir_b = d[27:16];
      end
      default: ;
    endcase
  endtask

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    check_count++;
    test_checks++;
    if (exp_v !== act_v) begin
      error_count++;
      test_errors++;
      $display("Fail %s %s expected %h actual %h", test_name(test_id), what, exp_v, act_v);
    end
  endtask

  task automatic report_error(input string msg);
    check_count++;
    test_checks++;
    error_count++;
    test_errors++;
    $display("%s: %s", test_name(test_id), msg);
  endtask

  //--------------------------------------------------------------------------
  // compare on the falling edge, away from the driving edge
  //--------------------------------------------------------------------------
  always @(negedge ctrlport_clk) begin
    if (ctrlport_rst !== 1'b0) begin
      m_scratch   = '0;
      m_dir_a     = '0;
      m_dir_b     = '0;
      m_clk_en    = 2'b00;
      m_pll       = 1'b0;
      m_rst       = 2'b11;
      exp_ack     = 1'b0;
      after_reset = 1'b1;
      check_count = 0;
      error_count = 0;
      test_count  = 0;
      test_checks = 0;
      test_errors = 0;
    end else begin
      // response to the request seen one cycle ago
      if (exp_ack) begin
        if (resp_ack !== 1'b1) begin
          report_error("no ack for in-range request");
        end else begin
          check_value("resp_status", exp_status, resp_status);
          check_value("resp_data", exp_data, resp_data);
        end
      end else if (resp_ack !== 1'b0) begin
        report_error("ack without a pending in-window request");
      end
      if (after_reset) begin
        check_value("reset resp_status", ctrl_sts_okay, resp_status);
        check_value("reset resp_data", 32'h0, resp_data);
        after_reset = 1'b0;
      end

      // configuration outputs follow the model every cycle
      check_value("db_clk_enable", m_clk_en, db_clk_enable);
      check_value("db_reset", m_rst, db_reset);
      check_value("pll_ref_clk_enable", m_pll, pll_ref_clk_enable);
      check_value("dio_direction_a", m_dir_a, dio_direction_a);
      check_value("dio_direction_b", m_dir_b, dio_direction_b);

      // new request, model moves to the post-edge state
      exp_ack = 1'b0;
      if ((req_wr || req_rd) &&
          req_addr[ctrlport_addr_w-1:6] == base_address[ctrlport_addr_w-1:6]) begin
        off        = req_addr[5:0];
        exp_ack    = 1'b1;
        exp_status = defined_offset(off) ? ctrl_sts_okay : ctrl_sts_cmderr;
        exp_data   = (req_wr || !defined_offset(off)) ? 32'h0 : read_word(off);
        if (req_wr)
          apply_write(off, req_data);
      end

      if (test_end) begin
        $display("test %s: %0d checks, %0d errors", test_name(test_id),
                 test_checks, test_errors);
        test_count++;
        test_checks = 0;
        test_errors = 0;
      end
    end
  end

endmodule

/* sim/tb_ps_cpld_regs.sv */
// testbench for the ps cpld base register block
//   clock, reset and cycle-limit timeout
//   seeded random controlport requests in five tests
//   checker instance and final verdict
`timescale 1ns/1ps

module tb_ps_cpld_regs;
  import ps_cpld_pkg::*;

  // window aligned to 64 words
  localparam logic [ctrlport_addr_w-1:0] base_address = 20'h0_04C0;

  localparam int id_writes   = 8;
  localparam int sd_loops    = 20;
  localparam int db_writes   = 200;
  localparam int bad_offsets = 20;
  localparam int bad_addrs   = 20;
  localparam int total_reqs  = 3 + 8 + id_writes + 4 * sd_loops + 2 * db_writes +
                               bad_offsets + bad_addrs;
  // each request is a pulse plus two idle cycles
  localparam int timeout_cycles = 3 * total_reqs + 20;

  logic                       ctrlport_clk;
  logic                       ctrlport_rst;
  logic                       req_wr;
  logic                       req_rd;
  logic [ctrlport_addr_w-1:0] req_addr;
  logic [ctrlport_data_w-1:0] req_data;
  logic                       resp_ack;
  logic [1:0]                 resp_status;
  logic [ctrlport_data_w-1:0] resp_data;
  logic [1:0]                 db_clk_enable;
  logic [1:0]                 db_reset;
  logic                       pll_ref_clk_enable;
  logic [dio_dir_w-1:0]       dio_direction_a;
  logic [dio_dir_w-1:0]       dio_direction_b;

  int                         test_id;
  logic                       test_end;
  int                         check_count;
  int                         error_count;
  int                         test_count;
  int                         assert_errors;
  int                         cycle_count;
  int                         seed;
  logic [5:0]                 off;
  logic [ctrlport_addr_w-1:0] addr;
  logic [5:0]                 id_offsets [4];

  ps_cpld_regs #(
    .base_address (base_address)
  ) UUT (
    .ctrlport_clk       (ctrlport_clk),
    .ctrlport_rst       (ctrlport_rst),
    .req_wr             (req_wr),
    .req_rd             (req_rd),
    .req_addr           (req_addr),
    .req_data           (req_data),
    .resp_ack           (resp_ack),
    .resp_status        (resp_status),
    .resp_data          (resp_data),
    .db_clk_enable      (db_clk_enable),
    .db_reset           (db_reset),
    .pll_ref_clk_enable (pll_ref_clk_enable),
    .dio_direction_a    (dio_direction_a),
    .dio_direction_b    (dio_direction_b)
  );

  ps_cpld_checker #(
    .base_address (base_address)
  ) checker_i (
    .*
  );

  always #50 ctrlport_clk = ~ctrlport_clk;

  // hard stop in case a test stalls
  always @(posedge ctrlport_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // request helpers, entered 1 ns after a rising edge
  //--------------------------------------------------------------------------
  task automatic send_request(input logic wr, input logic [ctrlport_addr_w-1:0] a,
                              input logic [ctrlport_data_w-1:0] d);
    req_wr   = wr;
    req_rd   = !wr;
    req_addr = a;
    req_data = d;
    @(posedge ctrlport_clk);
    #1;
    req_wr   = 1'b0;
    req_rd   = 1'b0;
    req_addr = '0;
    req_data = '0;
    // response cycle, then one spare
    repeat (2) begin
      @(posedge ctrlport_clk);
      #1;
    end
  endtask

  function automatic logic [ctrlport_addr_w-1:0] window_addr(input logic [5:0] o);
    return {base_address[ctrlport_addr_w-1:6], o};
  endfunction

  task automatic read_reg(input logic [5:0] o);
    send_request(1'b0, window_addr(o), '0);
  endtask

  task automatic write_reg(input logic [5:0] o, input logic [ctrlport_data_w-1:0] d);
    send_request(1'b1, window_addr(o), d);
  endtask

  task automatic close_test();
    test_end = 1'b1;
    @(posedge ctrlport_clk);
    #1;
    test_end = 1'b0;
  endtask

  function automatic logic is_register(input logic [5:0] o);
    return (o == 6'h00) || (o == 6'h04) || (o == 6'h08) || (o == 6'h0C) ||
           (o == 6'h10) || (o == 6'h20) || (o == 6'h30);
  endfunction

  //--------------------------------------------------------------------------
  // test sequence
  //--------------------------------------------------------------------------
  initial begin
    ctrlport_clk  = 1'b0;
    ctrlport_rst  = 1'b1;
    req_wr        = 1'b0;
    req_rd        = 1'b0;
    req_addr      = '0;
    req_data      = '0;
    test_id       = 0;
    test_end      = 1'b0;
    cycle_count   = 0;
    seed          = 66;
    id_offsets[0] = signature_reg;
    id_offsets[1] = revision_reg;
    id_offsets[2] = oldest_revision_reg;
    id_offsets[3] = git_hash_reg;
    repeat (2) @(posedge ctrlport_clk);
    #1;
    ctrlport_rst = 1'b0;

    // reset state, outputs checked every cycle by the checker
    test_id = 1;
    read_reg(pl_db_reg);
    read_reg(dio_direction_reg);
    read_reg(scratch_reg_addr);
    close_test();

    // id words, writes must leave them alone
    test_id = 2;
    for (int i = 0; i < 4; i++)
      read_reg(id_offsets[i]);
    for (int i = 0; i < id_writes; i++)
      write_reg(id_offsets[$unsigned($random(seed)) % 4], $random(seed));
    for (int i = 0; i < 4; i++)
      read_reg(id_offsets[i]);
    close_test();

    test_id = 3;
    for (int i = 0; i < sd_loops; i++) begin
      write_reg(scratch_reg_addr, $random(seed));
      read_reg(scratch_reg_addr);
      write_reg(dio_direction_reg, $random(seed));
      read_reg(dio_direction_reg);
    end
    close_test();

    // full random words, so both flags of a pair show up often
    test_id = 4;
    for (int i = 0; i < db_writes; i++) begin
      write_reg(pl_db_reg, $random(seed));
      read_reg(pl_db_reg);
    end
    close_test();

    test_id = 5;
    for (int i = 0; i < bad_offsets; i++) begin
      off = $random(seed);
      while (is_register(off))
        off = $random(seed);
      send_request(($random(seed) & 1) != 0, window_addr(off), $random(seed));
    end
    for (int i = 0; i < bad_addrs; i++) begin
      addr = $random(seed);
      while (addr[ctrlport_addr_w-1:6] == base_address[ctrlport_addr_w-1:6])
        addr = $random(seed);
      send_request(($random(seed) & 1) != 0, addr, $random(seed));
    end
    close_test();

    // protocol assertions bound into the decoder
    assert_errors = UUT.decoder_i.protocol_checks_i.fail_count;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", test_count,
             check_count, error_count, assert_errors);
    if (error_count == 0 && assert_errors == 0 && test_count == 5) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sources.f */
hw/ps_cpld_pkg.sv
hw/cfg_bus_if.sv
hw/ctrlport_decoder.sv
hw/config_regs.sv
hw/db_power_ctrl.sv
hw/ps_cpld_regs.sv
sim/ps_cpld_assertions.sv
sim/ps_cpld_checker.sv
sim/tb_ps_cpld_regs.sv
